//--- logic/basicOpUnit.sv
module basicOpUnit
(
	input logic clk,
	input logic reset,
	mathBus.unit math
);

	// Running sum for L_mult and L_mac
	fixedPointPkg::word32 accumulator;

	// Next values, worked out before the edge
	fixedPointPkg::word32 nextAccumulator;
	fixedPointPkg::word32 nextResult;

	//////////////////////////////////////////////////////////////////////
	// Saturating basic operations
	//////////////////////////////////////////////////////////////////////

	// Clamp a long value into 16 bits
	function automatic fixedPointPkg::word16 sat16(input fixedPointPkg::word32 value);
		if (value > fixedPointPkg::word32'(fixedPointPkg::MAX16))
			return fixedPointPkg::MAX16;
		if (value < fixedPointPkg::word32'(fixedPointPkg::MIN16))
			return fixedPointPkg::MIN16;
		return value[15:0];
	endfunction

	// mult is the product shifted down by 15
	function automatic fixedPointPkg::word16 mult(input fixedPointPkg::word16 a,
		input fixedPointPkg::word16 b);
		fixedPointPkg::word32 product;
		product = a * b;
		// Only min times min overflows here
		return sat16(product >>> 15);
	endfunction

	// L_mult doubles the product
	function automatic fixedPointPkg::word32 lMult(input fixedPointPkg::word16 a,
		input fixedPointPkg::word16 b);
		fixedPointPkg::word32 product;
		product = a * b;
		// 0x4000_0000 only from min times min
		if (product == 32'sh4000_0000)
			return fixedPointPkg::MAX32;
		return product <<< 1;
	endfunction

	// L_add with saturation on overflow
	function automatic fixedPointPkg::word32 lAdd(input fixedPointPkg::word32 a,
		input fixedPointPkg::word32 b);
		logic signed [32:0] sum;
		sum = {a[31], a} + {b[31], b};
		// Top two bits disagree on overflow
		if (sum[32] != sum[31])
			return sum[32] ? fixedPointPkg::MIN32 : fixedPointPkg::MAX32;
		return sum[31:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Operation select
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextAccumulator = accumulator;
		nextResult = accumulator;
		case (math.op)
			fixedPointPkg::opLMult:
			begin
				nextAccumulator = lMult(math.operandA, math.operandB);
				nextResult = nextAccumulator;
			end
			fixedPointPkg::opLMac:
			begin
				nextAccumulator = lAdd(accumulator, lMult(math.operandA, math.operandB));
				nextResult = nextAccumulator;
			end
			default:
			begin
				// mult leaves the accumulator alone
				nextResult = fixedPointPkg::word32'(mult(math.operandA, math.operandB));
			end
		endcase
	end

	// Accumulator is cleared by reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			accumulator <= '0;
		end
		else if (math.issue)
		begin
			accumulator <= nextAccumulator;
		end
	end

	// Result holds until the next issue
	always_ff @(posedge clk)
	begin
		if (math.issue)
		begin
			math.result <= nextResult;
		end
	end

endmodule

//--- logic/busInterfaces.sv
// Scratch memory port, one cycle read latency
interface memBus #(parameter int addrBits = 12);
	logic [addrBits-1:0] address;
	fixedPointPkg::word32 writeData;
	logic writeEnable;
	fixedPointPkg::word32 readData;

	// Engine or test port side
	modport master(output address, output writeData, output writeEnable, input readData);

	// RAM side
	modport memory(input address, input writeData, input writeEnable, output readData);
endinterface

// Basic operation request and result
interface mathBus;
	fixedPointPkg::mathOp op;
	fixedPointPkg::word16 operandA;
	fixedPointPkg::word16 operandB;
	logic issue;
	fixedPointPkg::word32 result;

	// Sequencer side
	modport client(output op, output operandA, output operandB, output issue, input result);

	// Arithmetic unit side
	modport unit(input op, input operandA, input operandB, input issue, output result);
endinterface

//--- logic/fixedPointPkg.sv
package fixedPointPkg;

	//////////////////////////////////////////////////////////////////////
	// Codec word types
	//////////////////////////////////////////////////////////////////////

	// Signed 16 bit codec word
	typedef logic signed [15:0] word16;

	// Signed 32 bit codec long word
	typedef logic signed [31:0] word32;

	// Saturation limits
	parameter word16 MAX16 = 16'sh7FFF;
	parameter word16 MIN16 = 16'sh8000;
	parameter word32 MAX32 = 32'sh7FFF_FFFF;
	parameter word32 MIN32 = 32'sh8000_0000;

	//////////////////////////////////////////////////////////////////////
	// Basic operation opcodes
	//////////////////////////////////////////////////////////////////////

	// mult returns a 16 bit result
	// L_mult loads the accumulator, L_mac adds to it
	typedef enum logic [1:0]
	{
		opMult,
		opLMult,
		opLMac
	} mathOp;

	//////////////////////////////////////////////////////////////////////
	// Lag window coefficient tables
	//////////////////////////////////////////////////////////////////////

	// Entry 0 belongs to k = 1
	// High halves of the double precision coefficients
	parameter word16 LAG_HIGH [10] = '{
		16'sd32728,
		16'sd32619,
		16'sd32438,
		16'sd32187,
		16'sd31867,
		16'sd31480,
		16'sd31029,
		16'sd30517,
		16'sd29946,
		16'sd29321
	};

	// Low halves, already scaled to the codec's split format
	parameter word16 LAG_LOW [10] = '{
		16'sd11904,
		16'sd17280,
		16'sd30720,
		16'sd25856,
		16'sd24192,
		16'sd28992,
		16'sd24384,
		16'sd7360,
		16'sd19520,
		16'sd14784
	};

endpackage

//--- logic/lagWindow.sv
module lagWindow
#(
	parameter int addrBits = 12
)
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	memBus.master mem,
	mathBus.client math
);

	// Coefficient index width
	localparam int kBits = $clog2(memoryMapPkg::COEFF_COUNT);

	// Index of the final coefficient
	localparam logic [kBits-1:0] lastK = kBits'(memoryMapPkg::COEFF_COUNT - 1);

	memoryMapPkg::windowState state;

	// Coefficient being worked on
	logic [kBits-1:0] kIndex;

	// Table entry for k, only used when k is nonzero
	logic [kBits-1:0] coeffIdx;

	// Word read for k and its split halves
	fixedPointPkg::word32 rWord;
	fixedPointPkg::word16 rHigh;
	fixedPointPkg::word16 rLow;

	// Region addresses for k
	logic [addrBits-1:0] readAddress;
	logic [addrBits-1:0] writeAddress;

	assign coeffIdx = kIndex - 1'b1;
	assign readAddress = addrBits'(memoryMapPkg::AUTOCORR_R) + addrBits'(kIndex);
	assign writeAddress = addrBits'(memoryMapPkg::LAG_WINDOW_R_PRIME) + addrBits'(kIndex);

	// Low half of the double precision split
	function automatic fixedPointPkg::word16 lowHalf(input fixedPointPkg::word32 r);
		fixedPointPkg::word32 shifted;
		fixedPointPkg::word32 highPart;
		fixedPointPkg::word32 diff;
		shifted = r >>> 1;
		highPart = fixedPointPkg::word32'(fixedPointPkg::word16'(r[31:16])) <<< 15;
		diff = shifted - highPart;
		return diff[15:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= memoryMapPkg::idle;
			kIndex <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				memoryMapPkg::idle:
				begin
					// Start while busy never reaches here
					if (start)
					begin
						kIndex <= '0;
						state <= memoryMapPkg::readR;
					end
				end
				memoryMapPkg::readR:
					state <= memoryMapPkg::splitR;
				memoryMapPkg::splitR:
				begin
					// r(0) skips the multiply
					if (kIndex == '0)
						state <= memoryMapPkg::writeR;
					else
						state <= memoryMapPkg::mpyHiHi;
				end
				memoryMapPkg::mpyHiHi:
					state <= memoryMapPkg::mpyHiLo;
				memoryMapPkg::mpyHiLo:
					state <= memoryMapPkg::macHiLo;
				memoryMapPkg::macHiLo:
					state <= memoryMapPkg::mpyLoHi;
				memoryMapPkg::mpyLoHi:
					state <= memoryMapPkg::macLoHi;
				memoryMapPkg::macLoHi:
					state <= memoryMapPkg::writeR;
				memoryMapPkg::writeR:
				begin
					if (kIndex == lastK)
					begin
						done <= 1'b1;
						state <= memoryMapPkg::idle;
					end
					else
					begin
						kIndex <= kIndex + 1'b1;
						state <= memoryMapPkg::readR;
					end
				end
				default:
					state <= memoryMapPkg::idle;
			endcase
		end
	end

	// Capture r(k) as it arrives and split it
	always_ff @(posedge clk)
	begin
		if (state == memoryMapPkg::splitR)
		begin
			rWord <= mem.readData;
			rHigh <= mem.readData[31:16];
			rLow <= lowHalf(mem.readData);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory and arithmetic requests
	//////////////////////////////////////////////////////////////////////

	// Read address in every state but writeR
	assign mem.address = (state == memoryMapPkg::writeR) ? writeAddress : readAddress;
	assign mem.writeEnable = (state == memoryMapPkg::writeR);
	// r(0) is copied unchanged
	assign mem.writeData = (kIndex == '0) ? rWord : math.result;

	// Five step Mpy_32 sequence
	always_comb
	begin
		math.op = fixedPointPkg::opMult;
		math.operandA = '0;
		math.operandB = '0;
		math.issue = 1'b0;
		case (state)
			memoryMapPkg::mpyHiHi:
			begin
				// Loads the accumulator
				math.op = fixedPointPkg::opLMult;
				math.operandA = rHigh;
				math.operandB = fixedPointPkg::LAG_HIGH[coeffIdx];
				math.issue = 1'b1;
			end
			memoryMapPkg::mpyHiLo:
			begin
				math.op = fixedPointPkg::opMult;
				math.operandA = rHigh;
				math.operandB = fixedPointPkg::LAG_LOW[coeffIdx];
				math.issue = 1'b1;
			end
			memoryMapPkg::macHiLo, memoryMapPkg::macLoHi:
			begin
				// Cross term from the cycle before, times one
				math.op = fixedPointPkg::opLMac;
				math.operandA = math.result[15:0];
				math.operandB = 16'sd1;
				math.issue = 1'b1;
			end
			memoryMapPkg::mpyLoHi:
			begin
				math.op = fixedPointPkg::opMult;
				math.operandA = rLow;
				math.operandB = fixedPointPkg::LAG_HIGH[coeffIdx];
				math.issue = 1'b1;
			end
			default:
			begin
				math.issue = 1'b0;
			end
		endcase
	end

endmodule

//--- logic/lagWindowTop.sv
module lagWindowTop
#(
	parameter int addrBits = memoryMapPkg::ADDR_BITS_DEFAULT
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic lagMuxSel,
	input logic testWriteEnable,
	input logic [addrBits-1:0] testWriteAddr,
	input logic [31:0] testWriteData,
	input logic [addrBits-1:0] testReadAddr,
	output logic done,
	output logic [31:0] readData
);

	// Engine side and RAM side of the memory port
	memBus #(.addrBits(addrBits)) engineBus();
	memBus #(.addrBits(addrBits)) memoryBus();

	// Engine to arithmetic unit
	mathBus mathLink();

	// Test port address, write address wins
	logic [addrBits-1:0] testAddress;

	assign testAddress = testWriteEnable ? testWriteAddr : testReadAddr;

	//////////////////////////////////////////////////////////////////////
	// Memory owner select
	//////////////////////////////////////////////////////////////////////

	// High hands the RAM to the test port
	assign memoryBus.address = lagMuxSel ? testAddress : engineBus.address;
	assign memoryBus.writeData = lagMuxSel ? testWriteData : engineBus.writeData;
	assign memoryBus.writeEnable = lagMuxSel ? testWriteEnable : engineBus.writeEnable;

	// Both owners see the same read word
	assign engineBus.readData = memoryBus.readData;
	assign readData = memoryBus.readData;

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	lagWindow #(.addrBits(addrBits)) engine
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.mem(engineBus.master),
		.math(mathLink.client)
	);

	basicOpUnit mathUnit
	(
		.clk(clk),
		.reset(reset),
		.math(mathLink.unit)
	);

	scratchMemory #(.addrBits(addrBits)) scratch
	(
		.clk(clk),
		.mem(memoryBus.memory)
	);

endmodule

//--- logic/memoryMapPkg.sv
package memoryMapPkg;

	//////////////////////////////////////////////////////////////////////
	// Scratch memory layout
	//////////////////////////////////////////////////////////////////////

	// Default scratch address width
	parameter int ADDR_BITS_DEFAULT = 12;

	// Autocorrelation words r(0) to r(10)
	parameter logic [11:0] AUTOCORR_R = 12'h040;

	// Windowed output r'(0) to r'(10)
	parameter logic [11:0] LAG_WINDOW_R_PRIME = 12'h050;

	// Coefficients per frame
	parameter int COEFF_COUNT = 11;

	//////////////////////////////////////////////////////////////////////
	// Lag window engine states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		idle,
		readR,
		splitR,
		mpyHiHi,
		mpyHiLo,
		macHiLo,
		mpyLoHi,
		macLoHi,
		writeR
	} windowState;

endpackage

//--- logic/scratchMemory.sv
module scratchMemory
#(
	parameter int addrBits = 12
)
(
	input logic clk,
	memBus.memory mem
);

	// Full address space of the scratch store
	localparam int depth = 2 ** addrBits;

	// Working data shared by the codec stages
	fixedPointPkg::word32 storage [depth];

	//////////////////////////////////////////////////////////////////////
	// Single port access
	//////////////////////////////////////////////////////////////////////

	// Write lands at the edge
	// Read is registered, old word on a same address write
	always_ff @(posedge clk)
	begin
		if (mem.writeEnable)
		begin
			storage[mem.address] <= mem.writeData;
		end
		mem.readData <= storage[mem.address];
	end

endmodule

//--- run.sh
#!/bin/bash
# Build and run the lag window testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lagWindowTb \
	-f vlog.f -o lagWindowSim > build.log 2>&1 \
	&& ./obj_dir/lagWindowSim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- test/lagWindowTb.sv
module lagWindowTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int addrBits = memoryMapPkg::ADDR_BITS_DEFAULT;
	localparam int coeffCount = memoryMapPkg::COEFF_COUNT;
	localparam int clkPeriod = 8;

	// Budget per engine run and the number of runs covered
	localparam int runCycles = 400;
	localparam int runLimit = 20;

	// Edge cases with low halves of all ones among them
	localparam int extremeA [11] = '{
		32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0000,
		32'hFFFF_FFFF, 32'h0000_FFFF, 32'h1234_FFFF, 32'h8000_FFFF,
		32'hFFFE_FFFF, 32'h7FFF_0000, 32'h0001_0001
	};
	localparam int extremeB [11] = '{
		32'h8000_0000, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF,
		32'h0000_0000, 32'h4000_FFFF, 32'hC000_FFFF, 32'h0001_FFFF,
		32'hFFFF_0000, 32'h8000_0001, 32'h7FFF_FFFF
	};

	logic clk;
	logic reset;
	logic start;
	logic lagMuxSel;
	logic testWriteEnable;
	logic [addrBits-1:0] testWriteAddr;
	logic [31:0] testWriteData;
	logic [addrBits-1:0] testReadAddr;
	logic done;
	logic [31:0] readData;

	// r(0) to r(10) of the current run
	int vector [coeffCount];
	int unsigned randState;
	int doneCount = 0;
	int checkFails = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	lagWindowTop #(.addrBits(addrBits)) uut
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.lagMuxSel(lagMuxSel),
		.testWriteEnable(testWriteEnable),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testReadAddr(testReadAddr),
		.done(done),
		.readData(readData)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Whole suite fits well inside this
	initial
	begin
		#(runLimit * runCycles * clkPeriod);
		$display("Watchdog expired before the test sequence finished");
		$display("TESTS FAILED");
		$finish;
	end

	// Done is sampled away from the rising edge
	always @(negedge clk)
	begin
		if (done === 1'b1)
			doneCount++;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic int unsigned nextRandom();
		randState ^= randState << 13;
		randState ^= randState >> 17;
		randState ^= randState << 5;
		return randState;
	endfunction

	function automatic longint clampLong(input longint value);
		if (value > longint'(fixedPointPkg::MAX32))
			return longint'(fixedPointPkg::MAX32);
		if (value < longint'(fixedPointPkg::MIN32))
			return longint'(fixedPointPkg::MIN32);
		return value;
	endfunction

	function automatic longint clampShort(input longint value);
		if (value > longint'(fixedPointPkg::MAX16))
			return longint'(fixedPointPkg::MAX16);
		if (value < longint'(fixedPointPkg::MIN16))
			return longint'(fixedPointPkg::MIN16);
		return value;
	endfunction

	// Codec mult shifts the product down by 15
	function automatic longint refMult(input longint a, input longint b);
		return clampShort((a * b) >>> 15);
	endfunction

	// Codec L_mult doubles the product
	function automatic longint refLMult(input longint a, input longint b);
		return clampLong(2 * a * b);
	endfunction

	// Split and then the 32 by 32 double precision product
	function automatic logic [31:0] expectedRPrime(input int r, input int k);
		longint rLong;
		longint high;
		longint low;
		longint lagHigh;
		longint lagLow;
		longint acc;
		if (k == 0)
			return r;
		rLong = longint'(r);
		high = rLong >>> 16;
		low = (rLong >>> 1) - (high <<< 15);
		lagHigh = longint'(fixedPointPkg::LAG_HIGH[k-1]);
		lagLow = longint'(fixedPointPkg::LAG_LOW[k-1]);
		acc = refLMult(high, lagHigh);
		acc = clampLong(acc + refLMult(refMult(high, lagLow), 1));
		acc = clampLong(acc + refLMult(refMult(low, lagHigh), 1));
		return 32'(acc);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Test port and engine control
	//////////////////////////////////////////////////////////////////////

	task automatic writeVector();
		for (int k = 0; k < coeffCount; k++)
		begin
			@(negedge clk);
			lagMuxSel = 1'b1;
			testWriteEnable = 1'b1;
			testWriteAddr = addrBits'(memoryMapPkg::AUTOCORR_R) + addrBits'(k);
			testWriteData = vector[k];
		end
		@(negedge clk);
		testWriteEnable = 1'b0;
	endtask

	// Word shows up one edge after the address
	task automatic readWord(input logic [addrBits-1:0] address, output logic [31:0] word);
		@(negedge clk);
		lagMuxSel = 1'b1;
		testWriteEnable = 1'b0;
		testReadAddr = address;
		@(negedge clk);
		word = readData;
	endtask

	// Engine takes the memory back for the run
	task automatic pulseStart();
		@(negedge clk);
		lagMuxSel = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic waitForDone(input string label);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < runCycles)
		begin
			if (done === 1'b1)
				seen = 1'b1;
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
		assert (seen)
		else
		begin
			$display("%s: engine never raised done within %0d cycles", label, runCycles);
			checkFails++;
		end
	endtask

	task automatic compareWord(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual);
			checkFails++;
		end
	endtask

	// Output region against the model and input region left untouched
	task automatic checkResults();
		logic [31:0] word;
		for (int k = 0; k < coeffCount; k++)
		begin
			readWord(addrBits'(memoryMapPkg::LAG_WINDOW_R_PRIME) + addrBits'(k), word);
			compareWord($sformatf("readData r-prime[%0d]", k), expectedRPrime(vector[k], k), word);
			readWord(addrBits'(memoryMapPkg::AUTOCORR_R) + addrBits'(k), word);
			compareWord($sformatf("readData r[%0d]", k), vector[k], word);
		end
	endtask

	task automatic checkDonePulses(input string label, input int donesBefore);
		assert (doneCount == donesBefore + 1)
		else
		begin
			$display("%s: saw %0d done cycles instead of one pulse", label,
				doneCount - donesBefore);
			checkFails++;
		end
	endtask

	task automatic reportTest(input string label, input int failsBefore);
		if (checkFails == failsBefore)
		begin
			testsPassed++;
			$display("test %s: ok", label);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d checks wrong", label, checkFails - failsBefore);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic idleAfterReset();
		int failsBefore;
		failsBefore = checkFails;
		repeat (20)
		begin
			@(negedge clk);
			compareWord("done", 32'h0, {31'b0, done});
		end
		reportTest("done idle after reset", failsBefore);
	endtask

	task automatic runVector(input string label);
		int failsBefore;
		int donesBefore;
		failsBefore = checkFails;
		writeVector();
		donesBefore = doneCount;
		pulseStart();
		waitForDone(label);
		checkResults();
		checkDonePulses(label, donesBefore);
		reportTest(label, failsBefore);
	endtask

	// Second start lands mid run
	task automatic busyStart();
		int failsBefore;
		int donesBefore;
		failsBefore = checkFails;
		for (int k = 0; k < coeffCount; k++)
			vector[k] = int'(nextRandom());
		writeVector();
		donesBefore = doneCount;
		pulseStart();
		repeat (4) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		waitForDone("start while busy");
		// Longer than a full run so a late second done is caught
		repeat (100) @(negedge clk);
		checkDonePulses("start while busy", donesBefore);
		checkResults();
		reportTest("start while busy", failsBefore);
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		lagMuxSel = 1'b1;
		testWriteEnable = 1'b0;
		testWriteAddr = '0;
		testWriteData = '0;
		testReadAddr = '0;
		randState = 32'd15171;
		// Two rising edges with reset high
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		idleAfterReset();
		for (int n = 0; n < 16; n++)
		begin
			for (int k = 0; k < coeffCount; k++)
				vector[k] = int'(nextRandom());
			runVector($sformatf("random vector %0d", n));
		end
		vector = extremeA;
		runVector("extreme vector a");
		vector = extremeB;
		runVector("extreme vector b");
		busyStart();

		$display("Summary: %0d tests ok, %0d tests failing", testsPassed, testsFailed);
		if (testsFailed == 0 && checkFails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
logic/fixedPointPkg.sv
logic/memoryMapPkg.sv
logic/busInterfaces.sv
logic/scratchMemory.sv
logic/basicOpUnit.sv
logic/lagWindow.sv
logic/lagWindowTop.sv
test/lagWindowTb.sv
